// ==== files.f ====
design/popeye_pkg.sv
design/video_timing.sv
design/cpu_port.sv
design/txt_layer.sv
design/obj_unit.sv
design/colmix.sv
design/popeye_video.sv
test/video_properties.sv
test/video_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= video_tb
FLAGS     ?= --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing $(FLAGS) --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== test/video_tb.sv ====
// clock and cen, cpu write handshake, frame reference model, directed and random tests
`timescale 1ns/1ns

module video_tb;

    logic                 clk;
    logic                 rst;
    logic                 cen;
    logic                 cpu_req;
    popeye_pkg::cpu_bus_t cpu;
    logic                 cpu_ack;
    popeye_pkg::rgb_t     rgb;
    logic                 blank;
    logic                 vs;
    int                   cycles = 0;

    logic [3:0] sh_cell [12]; // shadow copies for the model
    logic [5:0] sh_x [4];
    logic [4:0] sh_y [4];
    logic [3:0] sh_col [4];
    logic [8:0] sh_pal [16];

    popeye_video DUT (
        .clk (clk), .rst (rst), .cen (cen), .cpu_req (cpu_req), .cpu (cpu),
        .cpu_ack (cpu_ack), .rgb (rgb), .blank (blank), .vs (vs)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns
    end

    initial begin
        cen = 1'b0;
        forever begin
            @(posedge clk);
            #1 cen = ~cen; // one pixel every two clocks
        end
    end

    // 8 frame checks of up to 2 frames (2240 clocks each) plus writes
    always @(posedge clk) begin
        cycles++;
        if (cycles == 60000)
            fail_run("timeout: the run went past 60000 clocks");
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected)
            fail_run($sformatf("ERROR at %0t ns: %s, got %0h expected %0h",
                               $time, msg, actual, expected));
    endtask

    task automatic cpu_write(input popeye_pkg::cpu_tgt_e tgt, input logic [3:0] addr,
                             input logic [15:0] data);
        int n;
        @(posedge clk);
        #1;
        cpu     = '{tgt: tgt, addr: addr, data: data};
        cpu_req = 1'b1;
        for (n = 0; n < 4 && !cpu_ack; n++) begin
            @(posedge clk);
            #1;
        end
        if (!cpu_ack)
            fail_run("cpu_ack did not rise within 4 clocks of cpu_req");
        @(posedge clk); // req still high across this edge
        #1;
        check(32'(cpu_ack), 1, "cpu_ack held while cpu_req high");
        cpu_req = 1'b0; // phase 3
        for (n = 0; n < 4 && cpu_ack; n++) begin
            @(posedge clk);
            #1;
        end
        if (cpu_ack)
            fail_run("cpu_ack did not fall within 4 clocks after cpu_req dropped");
    endtask

    task automatic set_cell(input int idx, input logic [3:0] col);
        cpu_write(popeye_pkg::TGT_TXT, 4'(idx), {12'h000, col});
        sh_cell[4'(idx)] = col;
    endtask

    task automatic place_obj(input int n, input logic [5:0] x, input logic [4:0] y,
                             input logic [3:0] col);
        cpu_write(popeye_pkg::TGT_OBJ, 4'(n), {1'b0, x, y, col}); // x, y, col from msb
        sh_x[2'(n)]   = x;
        sh_y[2'(n)]   = y;
        sh_col[2'(n)] = col;
    endtask

    task automatic load_pal(input int idx, input logic [8:0] val);
        cpu_write(popeye_pkg::TGT_PAL, 4'(idx), {7'h00, val});
        sh_pal[4'(idx)] = val;
    endtask

    // expected {blank, rgb} for pixel (h, v)
    function automatic logic [9:0] model_pixel(input int h, input int v);
        int         i;
        int         dx;
        int         dy;
        logic [3:0] idx;
        if (h >= popeye_pkg::H_ACTIVE || v >= popeye_pkg::V_ACTIVE)
            return {1'b1, 9'h000};
        idx = sh_cell[4'((v / 8) * 4 + h / 8)]; // text wins if non-zero
        for (i = 0; i < 4 && idx == 4'h0; i++) begin
            dx = (h - int'(sh_x[2'(i)])) & 63; // wrap at counter width
            dy = (v - int'(sh_y[2'(i)])) & 31;
            if (dx < 8 && dy < 8)
                idx = sh_col[2'(i)]; // col 0 falls through to next sprite
        end
        return {1'b0, sh_pal[idx]};
    endfunction

    // step past the next cen edge and let outputs settle
    task automatic next_pixel();
        logic c;
        do begin
            @(posedge clk);
            c = cen;
            #2;
        end while (!c);
    endtask

    task automatic check_frame();
        int         h;
        int         v;
        int         line_act;
        logic [9:0] want;
        do next_pixel(); while (!vs); // pixel (0,0)
        for (v = 0; v < popeye_pkg::V_TOTAL; v++) begin
            line_act = 0;
            for (h = 0; h < popeye_pkg::H_TOTAL; h++) begin
                if (h != 0 || v != 0)
                    next_pixel();
                want = model_pixel(h, v);
                check(32'(vs), 32'(h == 0 && v == 0), $sformatf("vs at %0d,%0d", h, v));
                check(32'(blank), 32'(want[9]), $sformatf("blank at %0d,%0d", h, v));
                check(32'(rgb), 32'(want[8:0]), $sformatf("rgb at %0d,%0d", h, v));
                line_act += int'(!blank);
            end
            check(line_act, (v < popeye_pkg::V_ACTIVE) ? 32 : 0, "active pixels on a line");
        end
    endtask

    task automatic reset_state();
        check(32'(cpu_ack), 0, "cpu_ack after reset");
        check_frame(); // all-zero palette gives black
    endtask

    task automatic handshake_range();
        load_pal(5, 9'h1ff);
        cpu_write(popeye_pkg::TGT_TXT, 4'd13, 16'h0005);                // no cell 13
        cpu_write(popeye_pkg::TGT_OBJ, 4'd4, {1'b0, 6'd0, 5'd0, 4'd5}); // no sprite 4
        check_frame();
    endtask

    task automatic text_map();
        int i;
        for (i = 0; i < 16; i++)
            load_pal(i, 9'(i * 37 + 11)); // entry 0 visible too
        for (i = 0; i < 12; i++)
            set_cell(i, (i % 5 == 0) ? 4'h0 : 4'(i + 2)); // cells 0, 5, 10 empty
        check_frame();
    endtask

    task automatic sprite_overlap();
        int i;
        for (i = 0; i < 12; i++)
            set_cell(i, (i == 6) ? 4'd7 : 4'd0); // text at h16-23 v8-15 only
        place_obj(0, 6'd22, 5'd12, 4'd3);
        place_obj(1, 6'd20, 5'd14, 4'd4); // under sprite 0 at h22-27 v14-19
        place_obj(2, 6'd28, 5'd20, 4'd9); // runs past right and bottom edge
        place_obj(3, 6'd0, 5'd0, 4'd0);   // transparent
        check_frame();
    endtask

    task automatic palette_change();
        load_pal(4, 9'h0a5); // only sprite 1 uses index 4
        check_frame();
    endtask

    task automatic random_scenes();
        int f;
        int i;
        for (f = 0; f < 3; f++) begin
            for (i = 0; i < 16; i++)
                load_pal(i, 9'($urandom));
            for (i = 0; i < 12; i++)
                set_cell(i, ($urandom_range(0, 1) == 0) ? 4'h0 : 4'($urandom));
            for (i = 0; i < 4; i++)
                place_obj(i, 6'($urandom), 5'($urandom), 4'($urandom));
            check_frame();
        end
    endtask

    initial begin
        rst     = 1'b1;
        cpu_req = 1'b0;
        cpu     = '0;
        sh_cell = '{default: '0};
        sh_x    = '{default: '0};
        sh_y    = '{default: '0};
        sh_col  = '{default: '0};
        sh_pal  = '{default: '0};
        void'($urandom(32'hdf77_90e6));
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        reset_state();
        handshake_range();
        text_map();
        sprite_overlap();
        palette_change();
        random_scenes();
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== test/video_properties.sv ====
// concurrent checks on the cpu handshake, output blanking and vs period, bound to the top
`timescale 1ns/1ns

module video_properties (
    input logic             clk,
    input logic             rst,
    input logic             cen,
    input logic             cpu_req,
    input logic             cpu_ack,
    input logic             blank,
    input logic             vs,
    input popeye_pkg::rgb_t rgb
);

    logic        vs_q;
    logic        vs_seen;  // first vs already passed
    logic [11:0] cen_cnt;  // cen edges since vs rose

    always_ff @(posedge clk) begin
        if (rst) begin
            vs_q    <= 1'b0;
            vs_seen <= 1'b0;
            cen_cnt <= '0;
        end else begin
            vs_q <= vs;
            if (vs && !vs_q) begin
                vs_seen <= 1'b1;
                cen_cnt <= {11'b0, cen};
            end else if (cen) begin
                cen_cnt <= cen_cnt + 1'b1;
            end
        end
    end

    // ack is seen high one sample after the edge that raised it
    a_ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(cpu_ack) |-> $past(cpu_req))
        else $error("cpu_ack rose without cpu_req");
    a_ack_hold: assert property (@(posedge clk) disable iff (rst) cpu_ack && cpu_req |=> cpu_ack)
        else $error("cpu_ack dropped while cpu_req was still high");
    a_blank_rgb: assert property (@(posedge clk) disable iff (rst) blank |-> rgb == '0)
        else $error("rgb not zero during blank");
    a_frame: assert property (@(posedge clk) disable iff (rst)
        vs && !vs_q && vs_seen |-> cen_cnt == 12'(popeye_pkg::H_TOTAL * popeye_pkg::V_TOTAL))
        else $error("vs period is not one frame of cen cycles");

endmodule

bind popeye_video video_properties u_props (
    .clk (clk), .rst (rst), .cen (cen), .cpu_req (cpu_req), .cpu_ack (cpu_ack),
    .blank (blank), .vs (vs), .rgb (rgb)
);

// ==== design/popeye_video.sv ====
// video top level: timing, cpu port, text layer, sprite units and colour mixer
`timescale 1ns/1ns

module popeye_video (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,       // pixel enable
    input  logic                 cpu_req,
    input  popeye_pkg::cpu_bus_t cpu,
    output logic                 cpu_ack,
    output popeye_pkg::rgb_t     rgb,
    output logic                 blank,
    output logic                 vs         // one cen cycle, pixel (0,0)
);

    popeye_pkg::raster_t                     ras0;    // stage 0
    popeye_pkg::raster_t                     ras1;    // stage 1, lines up with layer colours
    popeye_pkg::col_t                        txt_col;
    popeye_pkg::col_t [popeye_pkg::N_OBJ-1:0] obj_col;

    logic                          txt_we;
    logic [popeye_pkg::N_OBJ-1:0]  obj_we;
    logic                          pal_we;
    logic [3:0]                    wr_addr;
    logic [15:0]                   wr_data;

    video_timing u_timing (
        .clk (clk), .rst (rst), .cen (cen),
        .ras (ras0)
    );

    cpu_port u_cpu (
        .clk     (clk),     .rst     (rst),
        .cpu_req (cpu_req), .cpu     (cpu),     .cpu_ack (cpu_ack),
        .txt_we  (txt_we),  .obj_we  (obj_we),  .pal_we  (pal_we),
        .wr_addr (wr_addr), .wr_data (wr_data)
    );

    txt_layer u_txt (
        .clk  (clk),     .rst  (rst),          .cen (cen),
        .we   (txt_we),  .addr (wr_addr),      .din (wr_data[3:0]),
        .ras  (ras0),    .txt_col (txt_col)
    );

    for (genvar i = 0; i < popeye_pkg::N_OBJ; i++) begin : g_obj
        obj_unit u_obj (
            .clk (clk),       .rst (rst), .cen (cen),
            .we  (obj_we[i]), .din (popeye_pkg::obj_attr_t'(wr_data[14:0])),
            .ras (ras0),      .obj_col (obj_col[i])
        );
    end

    // raster delay to match the registered layer outputs
    always_ff @(posedge clk) begin
        if (rst) begin
            ras1 <= '{blank: 1'b1, default: '0};
        end else if (cen) begin
            ras1 <= ras0;
        end
    end

    colmix u_colmix (
        .clk      (clk),     .rst      (rst),     .cen     (cen),
        .pal_we   (pal_we),  .pal_addr (wr_addr),
        .pal_din  (popeye_pkg::rgb_t'(wr_data[8:0])),
        .ras1     (ras1),    .txt_col  (txt_col), .obj_col (obj_col),
        .rgb      (rgb),     .blank    (blank),   .vs      (vs)
    );

endmodule

// ==== design/colmix.sv ====
// layer priority, palette lookup and rgb/blank/vs output stage
`timescale 1ns/1ns

module colmix (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          cen,
    input  logic                                          pal_we,
    input  logic [3:0]                                    pal_addr,
    input  popeye_pkg::rgb_t                              pal_din,
    input  popeye_pkg::raster_t                           ras1,    // stage 1 raster
    input  popeye_pkg::col_t                              txt_col,
    input  popeye_pkg::col_t [popeye_pkg::N_OBJ-1:0]      obj_col,
    output popeye_pkg::rgb_t                              rgb,
    output logic                                          blank,
    output logic                                          vs
);

    popeye_pkg::rgb_t pal [16];
    popeye_pkg::col_t obj_sel; // winning sprite colour
    popeye_pkg::col_t pix;     // final palette index

    // walk down so the lowest-numbered sprite is written last and wins
    always_comb begin
        obj_sel = '0;
        for (int i = popeye_pkg::N_OBJ - 1; i >= 0; i--) begin
            if (obj_col[i] != '0)
                obj_sel = obj_col[i];
        end
        pix = (txt_col != '0) ? txt_col : obj_sel; // text on top, else bg = 0
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++)
                pal[i] <= '0;
        end else if (pal_we) begin
            pal[pal_addr] <= pal_din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb   <= '0;
            blank <= 1'b1;
            vs    <= 1'b0;
        end else if (cen) begin
            rgb   <= ras1.blank ? '0 : pal[pix];
            blank <= ras1.blank;
            // first active pixel; the blank term keeps the reset value of ras1 out
            vs    <= !ras1.blank && ras1.h == '0 && ras1.v == '0;
        end
    end

endmodule

// ==== design/obj_unit.sv ====
// single sprite: attribute register and coverage test, stage 1
`timescale 1ns/1ns

module obj_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  logic                  we,
    input  popeye_pkg::obj_attr_t din,
    input  popeye_pkg::raster_t   ras,
    output popeye_pkg::col_t      obj_col  // 0 when not covering
);

    popeye_pkg::obj_attr_t attr;
    popeye_pkg::hpos_t     dx;
    popeye_pkg::vpos_t     dy;
    logic                  hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            attr <= '0; // col 0, sprite hidden
        end else if (we) begin
            attr <= din;
        end
    end

    // offsets wrap at counter width so left/above the sprite reads as large
    assign dx  = ras.h - attr.x;
    assign dy  = ras.v - attr.y;
    assign hit = dx < popeye_pkg::hpos_t'(popeye_pkg::CELL) &&
                 dy < popeye_pkg::vpos_t'(popeye_pkg::CELL) &&
                 !ras.blank; // clip at active edge

    always_ff @(posedge clk) begin
        if (rst) begin
            obj_col <= '0;
        end else if (cen) begin
            obj_col <= hit ? attr.col : '0;
        end
    end

endmodule

// ==== design/txt_layer.sv ====
// text cell map and per-pixel text colour, stage 1
`timescale 1ns/1ns

module txt_layer (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic                we,
    input  logic [3:0]          addr,
    input  popeye_pkg::col_t    din,
    input  popeye_pkg::raster_t ras,
    output popeye_pkg::col_t    txt_col
);

    // row-major, row * TXT_COLS + column
    popeye_pkg::col_t cells [popeye_pkg::TXT_COLS * popeye_pkg::TXT_ROWS];
    logic [3:0]       cell_idx;

    always_comb begin
        int row;
        int col;
        row      = int'(ras.v) / popeye_pkg::CELL;
        col      = int'(ras.h) / popeye_pkg::CELL;
        cell_idx = 4'(row * popeye_pkg::TXT_COLS + col); // only valid when active
    end

    // cpu writes, independent of cen
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < popeye_pkg::TXT_COLS * popeye_pkg::TXT_ROWS; i++)
                cells[i] <= '0;
        end else if (we) begin
            cells[addr] <= din; // range already checked upstream
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            txt_col <= '0;
        end else if (cen) begin
            txt_col <= ras.blank ? '0 : cells[cell_idx];
        end
    end

endmodule

// ==== design/cpu_port.sv ====
// four-phase req/ack write port, decodes target and range into layer strobes
`timescale 1ns/1ns

module cpu_port (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cpu_req,
    input  popeye_pkg::cpu_bus_t          cpu,
    output logic                          cpu_ack,
    output logic                          txt_we,
    output logic [popeye_pkg::N_OBJ-1:0]  obj_we,  // one-hot per sprite
    output logic                          pal_we,
    output logic [3:0]                    wr_addr,
    output logic [15:0]                   wr_data
);

    typedef enum logic {
        IDLE, // waiting for req
        ACK   // holding ack until req drops
    } state_e;

    state_e state;
    logic   fire; // the one cycle that writes

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (cpu_req) state <= ACK;
                ACK:     if (!cpu_req) state <= IDLE; // phase 3
                default: state <= IDLE;
            endcase
        end
    end

    assign cpu_ack = state == ACK;
    assign fire    = state == IDLE && cpu_req;

    // out-of-range writes still get acked, they just never strobe
    always_comb begin
        txt_we = fire && cpu.tgt == popeye_pkg::TGT_TXT &&
                 cpu.addr < 4'(popeye_pkg::TXT_COLS * popeye_pkg::TXT_ROWS);
        pal_we = fire && cpu.tgt == popeye_pkg::TGT_PAL; // all 16 entries exist
        for (int i = 0; i < popeye_pkg::N_OBJ; i++) begin
            obj_we[i] = fire && cpu.tgt == popeye_pkg::TGT_OBJ && cpu.addr == 4'(i);
        end
    end

    // bus is stable while req is high
    assign wr_addr = cpu.addr;
    assign wr_data = cpu.data;

endmodule

// ==== design/video_timing.sv ====
// raster counters with blanking, pacing the whole pixel pipeline
`timescale 1ns/1ns

module video_timing (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    output popeye_pkg::raster_t ras
);

    popeye_pkg::hpos_t h_cnt;
    popeye_pkg::vpos_t v_cnt;
    logic              h_last; // end of line
    logic              v_last; // end of frame
    logic              blank;

    assign h_last = h_cnt == popeye_pkg::hpos_t'(popeye_pkg::H_TOTAL - 1);
    assign v_last = v_cnt == popeye_pkg::vpos_t'(popeye_pkg::V_TOTAL - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (cen) begin
            if (h_last) begin
                h_cnt <= '0;
                // v only moves at the line wrap
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // hblank or vblank
    assign blank = (h_cnt >= popeye_pkg::hpos_t'(popeye_pkg::H_ACTIVE)) ||
                   (v_cnt >= popeye_pkg::vpos_t'(popeye_pkg::V_ACTIVE));

    assign ras = '{blank: blank, h: h_cnt, v: v_cnt}; // stage 0

endmodule

// ==== design/popeye_pkg.sv ====
// raster constants, position/colour types, cpu target enum and packed bus structs
package popeye_pkg;

    // reduced raster keeps simulation short
    localparam int H_ACTIVE = 32; // visible pixels per line
    localparam int H_TOTAL  = 40; // incl. horizontal blank
    localparam int V_ACTIVE = 24; // visible lines
    localparam int V_TOTAL  = 28; // incl. vertical blank

    localparam int N_OBJ    = 4;  // sprite units
    localparam int CELL     = 8;  // cell and sprite edge in pixels
    localparam int TXT_COLS = 4;  // text map columns
    localparam int TXT_ROWS = 3;  // text map rows

    localparam int HW = 6; // h counter width
    localparam int VW = 5; // v counter width

    typedef logic [HW-1:0] hpos_t;
    typedef logic [VW-1:0] vpos_t;
    typedef logic [3:0]    col_t;  // palette index where 0 is transparent

    // what a cpu write goes to
    typedef enum logic [1:0] {
        TGT_TXT, // text cell colour
        TGT_OBJ, // sprite attribute
        TGT_PAL  // palette entry
    } cpu_tgt_e;

    typedef struct packed {
        cpu_tgt_e    tgt;
        logic [3:0]  addr;
        logic [15:0] data;
    } cpu_bus_t; // 22 bits

    typedef struct packed {
        logic  blank; // outside the active area
        hpos_t h;
        vpos_t v;
    } raster_t; // 12 bits

    typedef struct packed {
        hpos_t x;   // left edge
        vpos_t y;   // top edge
        col_t  col; // 0 hides the sprite
    } obj_attr_t; // 15 bits

    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [2:0] b;
    } rgb_t; // 3/3/3

endpackage
